/* compile.f */
+incdir+include
design/redmule_pkg.sv
design/redmule_ctrl.sv
design/redmule_scheduler.sv
design/redmule_streamer.sv
design/redmule_stream_fifo.sv
design/redmule_engine.sv
design/redmule_top.sv
dv/tb_mem_model.sv
dv/tb_redmule.sv

/* design/redmule_ctrl.sv */
`timescale 1ns/1ns
`include "redmule_defs.svh"

module redmule_ctrl (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                periph_req_i,
  input  logic                periph_wen_i,
  input  logic [2:0]          periph_add_i,
  input  logic [`REG_W-1:0]   periph_data_i,
  input  logic                done_i,
  output logic [`REG_W-1:0]   periph_r_data_o,
  output logic                periph_r_valid_o,
  output logic                start_o,
  output logic [`ADDR_W-1:0]  x_addr_o,
  output logic [`ADDR_W-1:0]  w_addr_o,
  output logic [`ADDR_W-1:0]  y_addr_o,
  output logic [`ADDR_W-1:0]  z_addr_o,
  output logic [`ADDR_W-1:0]  n_size_o,
  output logic                busy_o,
  output logic                evt_o
);
  import redmule_pkg::*;

  reg_addr_e          reg_sel;
  logic               wr_acc;
  logic               rd_acc;
  logic               trigger;
  logic [`REG_W-1:0]  rd_value;

  assign reg_sel = reg_addr_e'(periph_add_i);
  // Registers are frozen while a job runs
  assign wr_acc  = periph_req_i && !periph_wen_i && !busy_o;
  assign rd_acc  = periph_req_i && periph_wen_i;
  assign trigger = wr_acc && (reg_sel == REG_TRIGGER);

  always_comb begin
    rd_value = '0;
    case (reg_sel)
      REG_X_ADDR: rd_value[`ADDR_W-1:0] = x_addr_o;
      REG_W_ADDR: rd_value[`ADDR_W-1:0] = w_addr_o;
      REG_Y_ADDR: rd_value[`ADDR_W-1:0] = y_addr_o;
      REG_Z_ADDR: rd_value[`ADDR_W-1:0] = z_addr_o;
      REG_N_SIZE: rd_value[`ADDR_W-1:0] = n_size_o;
      REG_STATUS: rd_value[0] = busy_o;
      default:    rd_value = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_o          <= 1'b0;
      busy_o           <= 1'b0;
      evt_o            <= 1'b0;
      periph_r_valid_o <= 1'b0;
    end else begin
      start_o          <= trigger;
      evt_o            <= done_i;
      periph_r_valid_o <= rd_acc;
      if (trigger) begin
        busy_o <= 1'b1;
      end else if (done_i) begin
        busy_o <= 1'b0;
      end
    end
  end

  // Job registers and read data
  always_ff @(posedge clk_i) begin
    if (rd_acc) begin
      periph_r_data_o <= rd_value;
    end
    if (wr_acc) begin
      case (reg_sel)
        REG_X_ADDR: x_addr_o <= periph_data_i[`ADDR_W-1:0];
        REG_W_ADDR: w_addr_o <= periph_data_i[`ADDR_W-1:0];
        REG_Y_ADDR: y_addr_o <= periph_data_i[`ADDR_W-1:0];
        REG_Z_ADDR: z_addr_o <= periph_data_i[`ADDR_W-1:0];
        REG_N_SIZE: n_size_o <= periph_data_i[`ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  // Done only closes a job that is already running
  a_done_in_job: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) done_i |-> busy_o && !start_o
  );

endmodule

/* design/redmule_engine.sv */
`timescale 1ns/1ns
`include "redmule_defs.svh"

module redmule_engine (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  redmule_pkg::engine_mode_e mode_i,
  input  logic                      op_valid_i,
  input  logic [`WORD_W-1:0]        op_data_i,
  input  logic                      z_ready_i,
  output logic                      op_ready_o,
  output logic                      op_done_o,
  output logic                      z_valid_o,
  output logic [`WORD_W-1:0]        z_row_o,
  output logic                      drain_done_o
);
  import redmule_pkg::*;

  localparam int unsigned ROW_W = $clog2(`ARRAY_WIDTH);

  logic [`ARRAY_WIDTH-1:0][`ARRAY_HEIGHT-1:0][`ELEM_W-1:0] acc_q;
  logic [`ARRAY_HEIGHT-1:0][`ELEM_W-1:0]                   op_elems;
  logic [`ARRAY_WIDTH-1:0][`ELEM_W-1:0]                    x_q;
  logic                                                    x_have_q;
  logic [ROW_W:0]                                          row_q;
  logic                                                    op_take, z_take;

  assign op_elems   = op_data_i;
  assign op_ready_o = (mode_i == MODE_BIAS) || (mode_i == MODE_MAC);
  assign op_take    = op_valid_i && op_ready_o;
  // row_q reaching ARRAY_WIDTH marks the drain as finished
  assign z_valid_o  = (mode_i == MODE_DRAIN) && (row_q != `ARRAY_WIDTH);
  assign z_row_o    = acc_q[row_q[ROW_W-1:0]];
  assign z_take     = z_valid_o && z_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      row_q        <= '0;
      x_have_q     <= 1'b0;
      op_done_o    <= 1'b0;
      drain_done_o <= 1'b0;
    end else begin
      op_done_o    <= 1'b0;
      drain_done_o <= 1'b0;
      case (mode_i)
        MODE_BIAS: if (op_take) begin
          if (row_q == `ARRAY_WIDTH-1) begin
            row_q     <= '0;
            op_done_o <= 1'b1;
          end else begin
            row_q <= row_q + 1'b1;
          end
        end
        // X column first, then the W row completes the pair
        MODE_MAC: if (op_take) begin
          x_have_q  <= !x_have_q;
          op_done_o <= x_have_q;
        end
        MODE_DRAIN: if (z_take) begin
          row_q        <= row_q + 1'b1;
          drain_done_o <= (row_q == `ARRAY_WIDTH-1);
        end
        default: begin
          row_q    <= '0;
          x_have_q <= 1'b0;
        end
      endcase
    end
  end

  // Rank-one update wraps modulo 2^16 per cell
  always_ff @(posedge clk_i) begin
    if (op_take && (mode_i == MODE_BIAS)) begin
      acc_q[row_q[ROW_W-1:0]] <= op_elems;
    end
    if (op_take && (mode_i == MODE_MAC)) begin
      if (!x_have_q) begin
        x_q <= op_elems[`ARRAY_WIDTH-1:0];
      end else begin
        for (int r = 0; r < `ARRAY_WIDTH; r++) begin
          for (int c = 0; c < `ARRAY_HEIGHT; c++) begin
            acc_q[r][c] <= acc_q[r][c] + x_q[r] * op_elems[c];
          end
        end
      end
    end
  end

  // No word may be left in the operand FIFO between jobs
  a_idle_no_operand: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) (mode_i == MODE_IDLE) |-> !op_valid_i
  );

endmodule

/* design/redmule_pkg.sv */
package redmule_pkg;

  // Peripheral register map, one word per index
  typedef enum logic [2:0] {
    REG_X_ADDR  = 3'd0,
    REG_W_ADDR  = 3'd1,
    REG_Y_ADDR  = 3'd2,
    REG_Z_ADDR  = 3'd3,
    REG_N_SIZE  = 3'd4,
    REG_TRIGGER = 3'd5,
    REG_STATUS  = 3'd6
  } reg_addr_e;

  // Job phases
  typedef enum logic [2:0] {
    S_IDLE,
    S_LOAD_Y,
    S_LOAD_X,
    S_LOAD_W,
    S_STORE_Z,
    S_DONE
  } sched_state_e;

  // What the array does with the operand and store streams
  typedef enum logic [1:0] {
    MODE_IDLE,
    MODE_BIAS,
    MODE_MAC,
    MODE_DRAIN
  } engine_mode_e;

endpackage

/* design/redmule_scheduler.sv */
`timescale 1ns/1ns
`include "redmule_defs.svh"

module redmule_scheduler (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      start_i,
  input  logic [`ADDR_W-1:0]        x_addr_i,
  input  logic [`ADDR_W-1:0]        w_addr_i,
  input  logic [`ADDR_W-1:0]        y_addr_i,
  input  logic [`ADDR_W-1:0]        z_addr_i,
  input  logic [`ADDR_W-1:0]        n_size_i,
  input  logic                      cmd_ready_i,
  input  logic                      op_done_i,
  input  logic                      drain_done_i,
  output logic                      cmd_valid_o,
  output logic                      cmd_write_o,
  output logic [`ADDR_W-1:0]        cmd_base_o,
  output logic [`ADDR_W-1:0]        cmd_count_o,
  output redmule_pkg::engine_mode_e mode_o,
  output logic                      done_o
);
  import redmule_pkg::*;

  sched_state_e        state_q;
  logic [`ADDR_W-1:0]  n_q;
  logic [`ADDR_W-1:0]  n_next;

  assign n_next = n_q + 1'b1;

  always_comb begin
    case (state_q)
      S_LOAD_Y:           mode_o = MODE_BIAS;
      S_LOAD_X, S_LOAD_W: mode_o = MODE_MAC;
      S_STORE_Z:          mode_o = MODE_DRAIN;
      default:            mode_o = MODE_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= S_IDLE;
      n_q         <= '0;
      cmd_valid_o <= 1'b0;
      cmd_write_o <= 1'b0;
      cmd_base_o  <= '0;
      cmd_count_o <= '0;
      done_o      <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (cmd_valid_o && cmd_ready_i) begin
        cmd_valid_o <= 1'b0;
      end
      case (state_q)
        S_IDLE: if (start_i) begin
          state_q     <= S_LOAD_Y;
          n_q         <= '0;
          cmd_valid_o <= 1'b1;
          cmd_write_o <= 1'b0;
          cmd_base_o  <= y_addr_i;
          cmd_count_o <= `ADDR_W'(`ARRAY_WIDTH);
        end
        // The engine flags the last bias row with op_done
        S_LOAD_Y: if (op_done_i) begin
          cmd_valid_o <= 1'b1;
          if (n_size_i == '0) begin
            state_q     <= S_STORE_Z;
            cmd_write_o <= 1'b1;
            cmd_base_o  <= z_addr_i;
          end else begin
            state_q     <= S_LOAD_X;
            cmd_base_o  <= x_addr_i;
            cmd_count_o <= `ADDR_W'(1);
          end
        end
        S_LOAD_X: if (cmd_valid_o && cmd_ready_i) begin
          state_q     <= S_LOAD_W;
          cmd_valid_o <= 1'b1;
          cmd_base_o  <= w_addr_i + n_q;
        end
        S_LOAD_W: if (op_done_i) begin
          n_q         <= n_next;
          cmd_valid_o <= 1'b1;
          if (n_next == n_size_i) begin
            state_q     <= S_STORE_Z;
            cmd_write_o <= 1'b1;
            cmd_base_o  <= z_addr_i;
            cmd_count_o <= `ADDR_W'(`ARRAY_WIDTH);
          end else begin
            state_q    <= S_LOAD_X;
            cmd_base_o <= x_addr_i + n_next;
          end
        end
        S_STORE_Z: if (drain_done_i) begin
          state_q <= S_DONE;
        end
        // Wait for the last store to be granted
        S_DONE: if (cmd_ready_i) begin
          state_q <= S_IDLE;
          done_o  <= 1'b1;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

/* design/redmule_stream_fifo.sv */
`timescale 1ns/1ns
`include "redmule_defs.svh"

module redmule_stream_fifo #(
  parameter int unsigned DEPTH = `FIFO_DEPTH
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      push_valid_i,
  input  logic [`WORD_W-1:0]        push_data_i,
  input  logic                      pop_ready_i,
  input  logic                      rd_pending_i,
  output logic                      push_ready_o,
  output logic                      pop_valid_o,
  output logic [`WORD_W-1:0]        pop_data_o,
  output logic [$clog2(DEPTH):0]    fifo_space_o
);
  localparam int unsigned PTR_W = $clog2(DEPTH);

  logic [`WORD_W-1:0]  mem_q [DEPTH];
  logic [PTR_W-1:0]    wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]      count_q, rsv_q;
  logic                push, pop;

  assign push_ready_o = (count_q != DEPTH);
  assign pop_valid_o  = (count_q != '0);
  assign pop_data_o   = mem_q[rd_ptr_q];
  assign push         = push_valid_i && push_ready_o;
  assign pop          = pop_valid_o && pop_ready_i;
  // Free slots not yet promised to a read in flight
  assign fifo_space_o = (PTR_W+1)'(DEPTH) - count_q - rsv_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      rsv_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + push - pop;
      rsv_q   <= rsv_q + rd_pending_i - push;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  a_no_push_full: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) push_valid_i |-> push_ready_o
  );

endmodule

/* design/redmule_streamer.sv */
`timescale 1ns/1ns
`include "redmule_defs.svh"

module redmule_streamer (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          cmd_valid_i,
  input  logic                          cmd_write_i,
  input  logic [`ADDR_W-1:0]            cmd_base_i,
  input  logic [`ADDR_W-1:0]            cmd_count_i,
  input  logic [$clog2(`FIFO_DEPTH):0]  fifo_space_i,
  input  logic                          mem_gnt_i,
  input  logic [`WORD_W-1:0]            mem_rdata_i,
  input  logic                          mem_r_valid_i,
  input  logic                          z_valid_i,
  input  logic [`WORD_W-1:0]            z_row_i,
  output logic                          cmd_ready_o,
  output logic                          mem_req_o,
  output logic                          mem_wen_o,
  output logic [`ADDR_W-1:0]            mem_add_o,
  output logic [`WORD_W-1:0]            mem_wdata_o,
  output logic                          ld_valid_o,
  output logic [`WORD_W-1:0]            ld_data_o,
  output logic                          z_ready_o
);
  logic                active_q, write_q, req_q;
  logic [`ADDR_W-1:0]  addr_q, req_left_q, cpl_left_q;
  logic [`WORD_W-1:0]  wdata_q;
  logic                grant, cpl, rd_go, z_take;

  assign grant  = req_q && mem_gnt_i;
  // Stores finish on grant, loads on their response
  assign cpl    = write_q ? grant : (mem_r_valid_i && active_q);
  // Only read when a FIFO slot is free for the answer
  assign rd_go  = active_q && !write_q && !req_q && (req_left_q != '0) && (fifo_space_i != '0);
  assign z_take = z_valid_i && z_ready_o;

  assign cmd_ready_o = !active_q;
  assign z_ready_o   = active_q && write_q && !req_q && (req_left_q != '0);
  assign mem_req_o   = req_q;
  assign mem_wen_o   = !write_q;
  assign mem_add_o   = addr_q;
  assign mem_wdata_o = wdata_q;
  assign ld_valid_o  = mem_r_valid_i && active_q && !write_q;
  assign ld_data_o   = mem_rdata_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q   <= 1'b0;
      write_q    <= 1'b0;
      req_q      <= 1'b0;
      addr_q     <= '0;
      req_left_q <= '0;
      cpl_left_q <= '0;
    end else begin
      if (cmd_valid_i && cmd_ready_o) begin
        active_q   <= (cmd_count_i != '0);
        write_q    <= cmd_write_i;
        addr_q     <= cmd_base_i;
        req_left_q <= cmd_count_i;
        cpl_left_q <= cmd_count_i;
      end
      if (rd_go || z_take) begin
        req_q <= 1'b1;
      end
      if (grant) begin
        req_q      <= 1'b0;
        addr_q     <= addr_q + 1'b1;
        req_left_q <= req_left_q - 1'b1;
      end
      if (cpl) begin
        cpl_left_q <= cpl_left_q - 1'b1;
        if (cpl_left_q == `ADDR_W'(1)) begin
          active_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (z_take) begin
      wdata_q <= z_row_i;
    end
  end

  a_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mem_req_o && !mem_gnt_i |=> mem_req_o && $stable(mem_wen_o) &&
      $stable(mem_add_o) && $stable(mem_wdata_o)
  );

endmodule

/* design/redmule_top.sv */
`timescale 1ns/1ns
`include "redmule_defs.svh"

module redmule_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                periph_req_i,
  input  logic                periph_wen_i,
  input  logic [2:0]          periph_add_i,
  input  logic [`REG_W-1:0]   periph_data_i,
  output logic [`REG_W-1:0]   periph_r_data_o,
  output logic                periph_r_valid_o,
  output logic                mem_req_o,
  output logic                mem_wen_o,
  output logic [`ADDR_W-1:0]  mem_add_o,
  output logic [`WORD_W-1:0]  mem_wdata_o,
  input  logic                mem_gnt_i,
  input  logic [`WORD_W-1:0]  mem_rdata_i,
  input  logic                mem_r_valid_i,
  output logic                busy_o,
  output logic                evt_o
);
  import redmule_pkg::*;

  logic                           start, done;
  logic [`ADDR_W-1:0]             x_addr, w_addr, y_addr, z_addr, n_size;
  logic                           cmd_valid, cmd_ready, cmd_write;
  logic [`ADDR_W-1:0]             cmd_base, cmd_count;
  logic [$clog2(`FIFO_DEPTH):0]   fifo_space;
  logic                           ld_valid;
  logic [`WORD_W-1:0]             ld_data;
  logic                           op_valid, op_ready, op_done;
  logic [`WORD_W-1:0]             op_data;
  logic                           z_valid, z_ready, drain_done;
  logic [`WORD_W-1:0]             z_row;
  logic                           rd_grant;
  engine_mode_e                   mode;

  // A granted read reserves one FIFO slot until its response lands
  assign rd_grant = mem_req_o && mem_gnt_i && mem_wen_o;

  redmule_ctrl i_ctrl (
    .clk_i            ( clk_i            ),
    .rst_n_i          ( rst_n_i          ),
    .periph_req_i     ( periph_req_i     ),
    .periph_wen_i     ( periph_wen_i     ),
    .periph_add_i     ( periph_add_i     ),
    .periph_data_i    ( periph_data_i    ),
    .done_i           ( done             ),
    .periph_r_data_o  ( periph_r_data_o  ),
    .periph_r_valid_o ( periph_r_valid_o ),
    .start_o          ( start            ),
    .x_addr_o         ( x_addr           ),
    .w_addr_o         ( w_addr           ),
    .y_addr_o         ( y_addr           ),
    .z_addr_o         ( z_addr           ),
    .n_size_o         ( n_size           ),
    .busy_o           ( busy_o           ),
    .evt_o            ( evt_o            )
  );

  redmule_scheduler i_scheduler (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .start_i      ( start      ),
    .x_addr_i     ( x_addr     ),
    .w_addr_i     ( w_addr     ),
    .y_addr_i     ( y_addr     ),
    .z_addr_i     ( z_addr     ),
    .n_size_i     ( n_size     ),
    .cmd_ready_i  ( cmd_ready  ),
    .op_done_i    ( op_done    ),
    .drain_done_i ( drain_done ),
    .cmd_valid_o  ( cmd_valid  ),
    .cmd_write_o  ( cmd_write  ),
    .cmd_base_o   ( cmd_base   ),
    .cmd_count_o  ( cmd_count  ),
    .mode_o       ( mode       ),
    .done_o       ( done       )
  );

  redmule_streamer i_streamer (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .cmd_valid_i   ( cmd_valid     ),
    .cmd_write_i   ( cmd_write     ),
    .cmd_base_i    ( cmd_base      ),
    .cmd_count_i   ( cmd_count     ),
    .fifo_space_i  ( fifo_space    ),
    .mem_gnt_i     ( mem_gnt_i     ),
    .mem_rdata_i   ( mem_rdata_i   ),
    .mem_r_valid_i ( mem_r_valid_i ),
    .z_valid_i     ( z_valid       ),
    .z_row_i       ( z_row         ),
    .cmd_ready_o   ( cmd_ready     ),
    .mem_req_o     ( mem_req_o     ),
    .mem_wen_o     ( mem_wen_o     ),
    .mem_add_o     ( mem_add_o     ),
    .mem_wdata_o   ( mem_wdata_o   ),
    .ld_valid_o    ( ld_valid      ),
    .ld_data_o     ( ld_data       ),
    .z_ready_o     ( z_ready       )
  );

  // Loads never outrun the reservation, so push_ready is not needed upstream
  redmule_stream_fifo i_fifo (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .push_valid_i ( ld_valid   ),
    .push_data_i  ( ld_data    ),
    .pop_ready_i  ( op_ready   ),
    .rd_pending_i ( rd_grant   ),
    .push_ready_o (            ),
    .pop_valid_o  ( op_valid   ),
    .pop_data_o   ( op_data    ),
    .fifo_space_o ( fifo_space )
  );

  redmule_engine i_engine (
    .clk_i        ( clk_i      ),
    .rst_n_i      ( rst_n_i    ),
    .mode_i       ( mode       ),
    .op_valid_i   ( op_valid   ),
    .op_data_i    ( op_data    ),
    .z_ready_i    ( z_ready    ),
    .op_ready_o   ( op_ready   ),
    .op_done_o    ( op_done    ),
    .z_valid_o    ( z_valid    ),
    .z_row_o      ( z_row      ),
    .drain_done_o ( drain_done )
  );

endmodule

/* dv/tb_mem_model.sv */
`timescale 1ns/1ns
`include "redmule_defs.svh"

module tb_mem_model (
  input  logic                clk_i,
  input  logic                stall_en_i,
  input  logic                req_i,
  input  logic                wen_i,
  input  logic [`ADDR_W-1:0]  add_i,
  input  logic [`WORD_W-1:0]  wdata_i,
  output logic                gnt_o,
  output logic [`WORD_W-1:0]  rdata_o,
  output logic                r_valid_o
);
  logic [`WORD_W-1:0]  mem_q [2**`ADDR_W];
  int                  wr_count [2**`ADDR_W];
  logic [31:0]         lfsr_q;

  // Galois LFSR, one step per grant bit
  function automatic logic [31:0] next_state(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  initial begin
    lfsr_q    = 32'h42bdeb32;
    gnt_o     = 1'b0;
    r_valid_o = 1'b0;
    rdata_o   = '0;
    // Background pattern built from the full word address
    for (int a = 0; a < 2**`ADDR_W; a++) begin
      mem_q[a]    = {4{a[15:0] ^ 16'hc3a5}};
      wr_count[a] = 0;
    end
  end

  always @(posedge clk_i) begin
    r_valid_o <= 1'b0;
    if (stall_en_i) begin
      gnt_o  <= lfsr_q[0];
      lfsr_q <= next_state(lfsr_q);
    end else begin
      gnt_o <= 1'b1;
    end
    // Transfer when request and the current grant meet
    if (req_i && gnt_o) begin
      if (wen_i) begin
        rdata_o   <= mem_q[add_i];
        r_valid_o <= 1'b1;
      end else begin
        mem_q[add_i]    <= wdata_i;
        wr_count[add_i] <= wr_count[add_i] + 1;
      end
    end
  end

endmodule

/* dv/tb_redmule.sv */
`timescale 1ns/1ns
`include "redmule_defs.svh"

module tb_redmule;
  import redmule_pkg::*;

  localparam int NUM_CASES = 8;
  localparam int MAX_N     = 8;

  typedef struct packed {
    logic [15:0] n_size;
    logic [15:0] x_addr;
    logic [15:0] w_addr;
    logic [15:0] y_addr;
    logic [15:0] z_addr;
    logic        stall;
    logic        retrig;
  } case_t;

  // N, X, W, Y, Z, grant stalls, second trigger while busy
  case_t test_table [NUM_CASES] = '{
    {16'd1, 16'h0000, 16'h0020, 16'h0040, 16'h0050, 1'b0, 1'b0},
    {16'd4, 16'h0100, 16'h0120, 16'h0140, 16'h0150, 1'b0, 1'b0},
    {16'd0, 16'h0200, 16'h0220, 16'h0240, 16'h0250, 1'b0, 1'b0},
    {16'd8, 16'h0300, 16'h0320, 16'h0340, 16'h0350, 1'b1, 1'b0},
    {16'd3, 16'h0400, 16'h0420, 16'h0440, 16'h0450, 1'b1, 1'b1},
    {16'd0, 16'h0500, 16'h0520, 16'h0540, 16'h0550, 1'b1, 1'b0},
    {16'd5, 16'h0600, 16'h0620, 16'h0640, 16'h0650, 1'b0, 1'b1},
    {16'd2, 16'h0710, 16'h0700, 16'h0790, 16'h07a0, 1'b1, 1'b0}
  };

  logic                clk, rst_n;
  logic                periph_req, periph_wen;
  logic [2:0]          periph_add;
  logic [`REG_W-1:0]   periph_data, periph_r_data;
  logic                periph_r_valid;
  logic                mem_req, mem_wen, mem_gnt, mem_r_valid;
  logic [`ADDR_W-1:0]  mem_add;
  logic [`WORD_W-1:0]  mem_wdata, mem_rdata;
  logic                busy, evt, stall_en;
  logic [31:0]         lfsr_q = 32'h42bdeb32;
  int                  evt_count;
  logic [`WORD_W-1:0]  y_rows [`ARRAY_WIDTH];
  logic [`WORD_W-1:0]  x_cols [MAX_N];
  logic [`WORD_W-1:0]  w_rows [MAX_N];

  redmule_top i_dut (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .periph_req_i     ( periph_req     ),
    .periph_wen_i     ( periph_wen     ),
    .periph_add_i     ( periph_add     ),
    .periph_data_i    ( periph_data    ),
    .periph_r_data_o  ( periph_r_data  ),
    .periph_r_valid_o ( periph_r_valid ),
    .mem_req_o        ( mem_req        ),
    .mem_wen_o        ( mem_wen        ),
    .mem_add_o        ( mem_add        ),
    .mem_wdata_o      ( mem_wdata      ),
    .mem_gnt_i        ( mem_gnt        ),
    .mem_rdata_i      ( mem_rdata      ),
    .mem_r_valid_i    ( mem_r_valid    ),
    .busy_o           ( busy           ),
    .evt_o            ( evt            )
  );

  tb_mem_model i_mem (
    .clk_i      ( clk         ),
    .stall_en_i ( stall_en    ),
    .req_i      ( mem_req     ),
    .wen_i      ( mem_wen     ),
    .add_i      ( mem_add     ),
    .wdata_i    ( mem_wdata   ),
    .gnt_o      ( mem_gnt     ),
    .rdata_o    ( mem_rdata   ),
    .r_valid_o  ( mem_r_valid )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("tests failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  // Galois LFSR, one step per random bit
  function logic random_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    return b;
  endfunction

  function logic [`WORD_W-1:0] random_word();
    logic [`WORD_W-1:0] w;
    w = '0;
    for (int i = 0; i < `WORD_W; i++) begin
      w = {w[`WORD_W-2:0], random_bit()};
    end
    return w;
  endfunction

  // Row r of Z = Y + X*W, every element wraps at 16 bits
  function automatic logic [`WORD_W-1:0] expected_row(input int r, input int n_size);
    logic [`ELEM_W-1:0]  acc;
    logic [`WORD_W-1:0]  row;
    row = '0;
    for (int c = 0; c < `ARRAY_HEIGHT; c++) begin
      acc = y_rows[r][c*`ELEM_W +: `ELEM_W];
      for (int n = 0; n < n_size; n++) begin
        acc = acc + x_cols[n][r*`ELEM_W +: `ELEM_W] * w_rows[n][c*`ELEM_W +: `ELEM_W];
      end
      row[c*`ELEM_W +: `ELEM_W] = acc;
    end
    return row;
  endfunction

  // Inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic reg_write(input logic [2:0] idx, input logic [`REG_W-1:0] data);
    periph_req  = 1'b1;
    periph_wen  = 1'b0;
    periph_add  = idx;
    periph_data = data;
    step();
    periph_req = 1'b0;
    periph_wen = 1'b1;
  endtask

  task automatic reg_read(input logic [2:0] idx, output logic [`REG_W-1:0] data);
    periph_req = 1'b1;
    periph_wen = 1'b1;
    periph_add = idx;
    step();
    periph_req = 1'b0;
    check_value("periph_r_valid_o", periph_r_valid, 1);
    data = periph_r_data;
  endtask

  task automatic run_case(input case_t tc);
    logic [`REG_W-1:0]  rd;
    int                 n;
    n = tc.n_size;
    for (int r = 0; r < `ARRAY_WIDTH; r++) begin
      y_rows[r] = random_word();
      i_mem.mem_q[tc.y_addr + r] = y_rows[r];
    end
    for (int k = 0; k < n; k++) begin
      x_cols[k] = random_word();
      w_rows[k] = random_word();
      i_mem.mem_q[tc.x_addr + k] = x_cols[k];
      i_mem.mem_q[tc.w_addr + k] = w_rows[k];
    end
    stall_en = tc.stall;
    reg_write(REG_X_ADDR, tc.x_addr);
    reg_write(REG_W_ADDR, tc.w_addr);
    reg_write(REG_Y_ADDR, tc.y_addr);
    reg_write(REG_Z_ADDR, tc.z_addr);
    reg_write(REG_N_SIZE, tc.n_size);
    reg_read(REG_X_ADDR, rd);
    check_value("x_addr register", rd, tc.x_addr);
    reg_read(REG_W_ADDR, rd);
    check_value("w_addr register", rd, tc.w_addr);
    reg_read(REG_Y_ADDR, rd);
    check_value("y_addr register", rd, tc.y_addr);
    reg_read(REG_Z_ADDR, rd);
    check_value("z_addr register", rd, tc.z_addr);
    reg_read(REG_N_SIZE, rd);
    check_value("n_size register", rd, tc.n_size);
    evt_count = 0;
    reg_write(REG_TRIGGER, 1);
    reg_read(REG_STATUS, rd);
    check_value("status busy bit", rd[0], 1);
    // Both writes land while the job runs and must change nothing
    if (tc.retrig) begin
      reg_write(REG_TRIGGER, 1);
      reg_write(REG_Z_ADDR, tc.z_addr + 16'h0800);
    end
    while (!evt) begin
      step();
    end
    check_value("busy_o", busy, 0);
    repeat (8) step();
    check_value("evt_o pulse count", evt_count, 1);
    reg_read(REG_STATUS, rd);
    check_value("status busy bit", rd[0], 0);
    reg_read(REG_Z_ADDR, rd);
    check_value("z_addr register", rd, tc.z_addr);
    for (int r = 0; r < `ARRAY_WIDTH; r++) begin
      check_value($sformatf("Z row %0d", r), i_mem.mem_q[tc.z_addr + r], expected_row(r, n));
      check_value($sformatf("Z row %0d write count", r), i_mem.wr_count[tc.z_addr + r], 1);
    end
  endtask

  // evt_o is stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && evt) begin
      evt_count = evt_count + 1;
      check_value("busy_o at evt_o", busy, 0);
    end
  end

  initial begin
    int unsigned budget;
    budget = 0;
    for (int i = 0; i < NUM_CASES; i++) begin
      budget = budget + 200 + 40 * test_table[i].n_size;
    end
    repeat (budget) @(posedge clk);
    $display("Watchdog expired before the jobs finished");
    $display("tests failed");
    $fatal(1, "Watchdog timeout");
  end

  initial begin
    rst_n       = 1'b0;
    periph_req  = 1'b0;
    periph_wen  = 1'b1;
    periph_add  = '0;
    periph_data = '0;
    stall_en    = 1'b0;
    evt_count   = 0;
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    step();
    for (int i = 0; i < NUM_CASES; i++) begin
      run_case(test_table[i]);
    end
    $display("all tests passed");
    $finish;
  end

endmodule

/* include/redmule_defs.svh */
`ifndef REDMULE_DEFS_SVH
`define REDMULE_DEFS_SVH

// Tile size of the accumulator array
`define ARRAY_WIDTH  4
`define ARRAY_HEIGHT 4

// Element and memory word widths
`define ELEM_W 16
`define WORD_W (`ARRAY_HEIGHT * `ELEM_W)

// Word address and peripheral data widths
`define ADDR_W 16
`define REG_W  32

// Default depth of the operand FIFO
`define FIFO_DEPTH 4

`endif
